//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Datapath sizing
	localparam int dataWidth = 16;    // Data words, registers, PC and instructions
	localparam int regCount = 4;      // General registers r0..r3
	localparam int regIndexWidth = 2; // Enough bits to pick one of regCount

	// Instruction opcodes, top nibble of the instruction word
	typedef enum logic [3:0] {
		ADD   = 4'b0000,
		LDIMM = 4'b1010,
		LDIND = 4'b1011,
		MV    = 4'b1100,
		STIND = 4'b1101,
		BRIMM = 4'b1110,
		BRIND = 4'b1111
	} opcode_e;

	// ALU operations, codes shared with the opcodes they serve
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_PASS = 4'b1100
	} aluOp_e;

	// Source of the next PC
	typedef enum logic [1:0] {
		PC_INC = 2'b00, // Sequential flow
		PC_IMM = 2'b01, // Payload of a taken immediate branch
		PC_REG = 2'b10  // Source 1 of a taken indirect branch
	} nextPcSel_e;

	// Control word from the decoder
	typedef struct packed {
		nextPcSel_e nextPcSel;
		logic       regDataInSource; // 1 = write back from memory
		logic       immData;         // 1 = write back the payload
		logic       regFileWE;
		logic       flagWE;          // Only ADD touches the flags
		aluOp_e     aluOp;
		logic       memWE;
		logic       dAddrSel;        // Drive the data address from source 1
	} ctrl_t;

	// Data memory port driven by the core
	typedef struct packed {
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wData;
		logic                 we;
	} dataBus_t;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder import cpuPkg::*; (
	input wire logic [dataWidth-1:0] instruction,
	input wire logic cFlag,                          // Carry, for branch conditions
	input wire logic zFlag,                          // Zero, for branch conditions
	output ctrl_t ctrl,
	output logic [regIndexWidth-1:0] regDst,
	output logic [regIndexWidth-1:0] regSrc1,
	output logic [regIndexWidth-1:0] regSrc2,
	output logic [dataWidth-1:0] instrData           // Payload, zero-extended
);

	opcode_e opcode;
	logic [7:0] payload;
	logic brFlagSel;                                 // 0 = carry, 1 = zero
	logic brFlag;                                    // Flag value the branch wants
	logic brCond;
	logic brTaken;
	logic [dataWidth-1:0] payloadExt;

	// Fixed field positions, parsed whether or not the opcode uses them
	assign opcode = opcode_e'(instruction[15:12]);
	assign regDst = instruction[11:10];
	assign regSrc1 = instruction[9:8];
	assign regSrc2 = instruction[7:6];

	// Branches reuse the destination field as flag select and value
	assign brFlagSel = instruction[11];
	assign brFlag = instruction[10];

	assign payload = instruction[7:0];
	assign payloadExt = {{(dataWidth - 8){1'b0}}, payload};

	assign brCond = brFlagSel ? zFlag : cFlag;
	assign brTaken = (brFlag == brCond);

	always_comb begin
		// Defaults give a no-op that just steps the PC
		ctrl = '0;
		ctrl.nextPcSel = PC_INC;
		ctrl.aluOp = ALU_ADD;
		instrData = '0;

		case (opcode)
			ADD: begin
				ctrl.regFileWE = 1'b1; // Sum goes back to rd
				ctrl.flagWE = 1'b1;    // Carry and zero follow the sum
				ctrl.aluOp = ALU_ADD;
			end

			LDIMM: begin
				ctrl.immData = 1'b1;   // Write back the payload
				ctrl.regFileWE = 1'b1;
				instrData = payloadExt;
			end

			LDIND: begin
				ctrl.dAddrSel = 1'b1;        // Address from rs1
				ctrl.regDataInSource = 1'b1; // Write back read data
				ctrl.regFileWE = 1'b1;
			end

			MV: begin
				ctrl.regFileWE = 1'b1;
				ctrl.aluOp = ALU_PASS; // rs1 straight through
			end

			STIND: begin
				ctrl.dAddrSel = 1'b1;
				ctrl.memWE = 1'b1;     // rs2 goes out as write data
			end

			BRIMM: begin
				if (brTaken) begin
					ctrl.nextPcSel = PC_IMM;
					instrData = payloadExt; // Target only shown when taken
				end
			end

			BRIND: begin
				if (brTaken) begin
					ctrl.nextPcSel = PC_REG; // Target is rs1
				end
			end

			default: begin
				// Undefined opcode, nothing but the PC step
			end
		endcase
	end

	// A store never writes back, and nothing else writes memory
	always_comb begin
		assert (!(ctrl.memWE && ctrl.regFileWE))
			else $error("decoder: memWE and regFileWE both set, instruction %h", instruction);
	end

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic we,
	input wire logic [regIndexWidth-1:0] wIndex,
	input wire logic [dataWidth-1:0] wData,
	input wire logic [regIndexWidth-1:0] rIndex1,
	input wire logic [regIndexWidth-1:0] rIndex2,
	output logic [dataWidth-1:0] rData1,
	output logic [dataWidth-1:0] rData2
);

	logic [dataWidth-1:0] regs [regCount];

	// Single write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; // Architectural state starts at zero
			end
		end else if (we) begin
			regs[wIndex] <= wData;
		end
	end

	// Async reads, no bypass: a same-cycle write shows up next cycle
	assign rData1 = regs[rIndex1];
	assign rData2 = regs[rIndex2];

	// A write with a floating index would corrupt an unknown register
	assert property (@(posedge clk) disable iff (reset)
		we |-> !$isunknown(wIndex))
		else $error("regFile: write with unknown index");

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire aluOp_e aluOp,
	input wire logic flagWE,                 // Only set for ADD
	input wire logic [dataWidth-1:0] a,      // rs1 data
	input wire logic [dataWidth-1:0] b,      // rs2 data
	output logic [dataWidth-1:0] result,
	output logic cFlag,
	output logic zFlag
);

	logic [dataWidth:0] sum; // One extra bit for carry out
	logic carryOut;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = '0;
		carryOut = 1'b0;

		case (aluOp)
			ALU_ADD: begin
				result = sum[dataWidth-1:0];
				carryOut = sum[dataWidth];
			end

			ALU_PASS: begin
				result = a; // MV copies source 1
			end

			default: begin
				result = '0;
			end
		endcase
	end

	// Flags register, updated at the end of an ADD cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWE) begin
			cFlag <= carryOut;
			zFlag <= (result == '0);
		end
	end

	// Flag writes come only from add
	assert property (@(posedge clk) disable iff (reset)
		flagWE |-> aluOp == ALU_ADD)
		else $error("alu: flag write on non-add op %h", aluOp);

endmodule

`default_nettype wire

//--- source/pcUnit.sv
`timescale 1ns/10ps
`default_nettype none

module pcUnit import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire nextPcSel_e nextPcSel,
	input wire logic [dataWidth-1:0] instrData, // Immediate branch target
	input wire logic [dataWidth-1:0] regData,   // Indirect branch target
	output logic [dataWidth-1:0] pc
);

	logic [dataWidth-1:0] nextPc;

	always_comb begin
		case (nextPcSel)
			PC_IMM:  nextPc = instrData;
			PC_REG:  nextPc = regData;
			default: nextPc = pc + 1'b1; // Wraps at the top of the address space
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0; // First fetch from address 0
		end else begin
			pc <= nextPc; // No stall, loads every cycle
		end
	end

	// Immediate targets only reach the low 256 words
	assert property (@(posedge clk) disable iff (reset)
		nextPcSel == PC_IMM |-> instrData[dataWidth-1:8] == '0)
		else $error("pcUnit: immediate target %h out of range", instrData);

endmodule

`default_nettype wire

//--- source/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore import cpuPkg::*; (
	input wire logic clk,
	input wire logic reset,
	output logic [dataWidth-1:0] instrAddr,
	input wire logic [dataWidth-1:0] instruction,
	output dataBus_t dataBus,
	input wire logic [dataWidth-1:0] dataIn     // Read data, same cycle as addr
);

	ctrl_t ctrl;
	logic [regIndexWidth-1:0] regDst;
	logic [regIndexWidth-1:0] regSrc1;
	logic [regIndexWidth-1:0] regSrc2;
	logic [dataWidth-1:0] instrData;
	logic [dataWidth-1:0] rData1;
	logic [dataWidth-1:0] rData2;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] wbData;       // Write-back value
	logic regWE;
	logic cFlag;
	logic zFlag;
	logic [dataWidth-1:0] pc;

	decoder u_decoder (
		.instruction (instruction),
		.cFlag       (cFlag),
		.zFlag       (zFlag),
		.ctrl        (ctrl),
		.regDst      (regDst),
		.regSrc1     (regSrc1),
		.regSrc2     (regSrc2),
		.instrData   (instrData)
	);

	// No register writes while held in reset
	assign regWE = ctrl.regFileWE && !reset;

	regFile u_regFile (
		.clk     (clk),
		.reset   (reset),
		.we      (regWE),
		.wIndex  (regDst),
		.wData   (wbData),
		.rIndex1 (regSrc1),
		.rIndex2 (regSrc2),
		.rData1  (rData1),
		.rData2  (rData2)
	);

	alu u_alu (
		.clk    (clk),
		.reset  (reset),
		.aluOp  (ctrl.aluOp),
		.flagWE (ctrl.flagWE),
		.a      (rData1),
		.b      (rData2),
		.result (aluResult),
		.cFlag  (cFlag),
		.zFlag  (zFlag)
	);

	pcUnit u_pcUnit (
		.clk       (clk),
		.reset     (reset),
		.nextPcSel (ctrl.nextPcSel),
		.instrData (instrData),
		.regData   (rData1), // Indirect branch target
		.pc        (pc)
	);

	assign instrAddr = pc;

	// Write-back source, payload wins over memory over ALU
	assign wbData = ctrl.immData ? instrData :
		ctrl.regDataInSource ? dataIn : aluResult;

	// Data port
	assign dataBus.addr = ctrl.dAddrSel ? rData1 : '0;
	assign dataBus.wData = rData2;
	assign dataBus.we = ctrl.memWE && !reset; // No stores during reset

	// Fetch restarts at zero once reset has been seen at an edge
	assert property (@(posedge clk) reset |=> instrAddr == '0)
		else $error("cpuCore: instrAddr %h after reset", instrAddr);

endmodule

`default_nettype wire

//--- test/cpuCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();

	logic clk;
	logic reset;
	logic [dataWidth-1:0] instrAddr;
	logic [dataWidth-1:0] instruction;
	logic [dataWidth-1:0] dataIn;
	dataBus_t dataBus;

	// External memories indexed by the low address byte
	logic [dataWidth-1:0] progRom [256];
	logic [dataWidth-1:0] dataMem [256];

	// Reference model state
	logic [dataWidth-1:0] mRegs [regCount];
	logic [dataWidth-1:0] mMem [256]; // Model's own copy of data memory
	logic [dataWidth-1:0] mPc;
	logic mCarry;
	logic mZero;

	integer seed;
	int wordErrors;
	int busErrors;
	int otherErrors;
	int cycleNum;

	cpuCore u_cpuCore (
		.clk         (clk),
		.reset       (reset),
		.instrAddr   (instrAddr),
		.instruction (instruction),
		.dataBus     (dataBus),
		.dataIn      (dataIn)
	);

	always #2 clk = ~clk; // 4 ns period

	// Memories answer within the cycle
	assign instruction = progRom[instrAddr[7:0]];
	assign dataIn = dataMem[dataBus.addr[7:0]];

	always @(posedge clk) begin
		if (dataBus.we) begin
			dataMem[dataBus.addr[7:0]] <= dataBus.wData; // Store lands at the edge
		end
	end

	task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] expected);
		if (got !== expected) begin
			wordErrors++;
			$display("[FAIL] %s got %h expected %h in cycle %0d", name, got, expected, cycleNum);
		end
	endtask

	task automatic checkBus(input dataBus_t got, input dataBus_t expected);
		if (got !== expected) begin
			busErrors++;
			$display("[FAIL] dataBus got addr %h wData %h we %h expected addr %h wData %h we %h",
				got.addr, got.wData, got.we, expected.addr, expected.wData, expected.we);
		end
	endtask

	// Random instruction weighted toward defined opcodes
	task automatic makeInstr(output logic [dataWidth-1:0] instr);
		logic [31:0] pick;
		logic [31:0] fields;
		logic [3:0] op;
		logic [3:0] undefOp;

		pick = $random(seed);
		fields = $random(seed);
		undefOp = fields[19:16] % 4'd9; // 0..8 before the shift into 0001..1001
		if (pick % 100 < 20) op = ADD;
		else if (pick % 100 < 35) op = LDIMM;
		else if (pick % 100 < 45) op = LDIND;
		else if (pick % 100 < 55) op = MV;
		else if (pick % 100 < 70) op = STIND;
		else if (pick % 100 < 80) op = BRIMM;
		else if (pick % 100 < 90) op = BRIND;
		else op = undefOp + 4'd1; // About 10% undefined
		instr = {op, fields[11:0]};
	endtask

	task automatic fillMemories();
		logic [31:0] rnd;
		logic [dataWidth-1:0] word;

		for (int i = 0; i < 256; i++) begin
			makeInstr(word);
			progRom[i] = word;
			rnd = $random(seed);
			dataMem[i] = rnd[15:0];
			if (rnd[18:16] == 3'd0) begin
				dataMem[i] = 16'hffff; // All ones for carries and PC wrap via BRIND
			end
			mMem[i] = dataMem[i];
		end
		// Store at address 0 is on the bus all through reset
		progRom[0] = {STIND, 12'h000};
	endtask

	// One instruction by the ISA rules and the bus the core should show
	task automatic stepModel(output dataBus_t expBus);
		logic [dataWidth-1:0] instr;
		logic [dataWidth:0] sum;
		logic [regIndexWidth-1:0] rd;
		logic [regIndexWidth-1:0] rs1;
		logic [regIndexWidth-1:0] rs2;
		logic cond;

		instr = progRom[mPc[7:0]];
		rd = instr[11:10];
		rs1 = instr[9:8];
		rs2 = instr[7:6];
		cond = instr[11] ? mZero : mCarry; // Branch flag select
		expBus.addr = '0;                  // Address idles at zero
		expBus.wData = mRegs[rs2];
		expBus.we = 1'b0;
		mPc = mPc + 16'd1;                 // Default step wrapping at 16 bits

		case (instr[15:12])
			ADD: begin
				sum = {1'b0, mRegs[rs1]} + {1'b0, mRegs[rs2]};
				mRegs[rd] = sum[15:0];
				mCarry = sum[16];
				mZero = (sum[15:0] == 16'h0000);
			end
			LDIMM: mRegs[rd] = {8'h00, instr[7:0]};
			LDIND: begin
				expBus.addr = mRegs[rs1];
				mRegs[rd] = mMem[mRegs[rs1][7:0]];
			end
			MV: mRegs[rd] = mRegs[rs1];
			STIND: begin
				expBus.addr = mRegs[rs1];
				expBus.we = 1'b1;
				mMem[mRegs[rs1][7:0]] = mRegs[rs2];
			end
			BRIMM: if (cond == instr[10]) mPc = {8'h00, instr[7:0]};
			BRIND: if (cond == instr[10]) mPc = mRegs[rs1];
			default: begin
				// Undefined opcode steps the PC only
			end
		endcase
	endtask

	task automatic runProgram();
		dataBus_t expBus;

		for (int n = 0; n < 2000; n++) begin
			@(negedge clk); // Mid-cycle with everything settled
			cycleNum = n;
			checkWord("instrAddr", instrAddr, mPc);
			stepModel(expBus);
			checkBus(dataBus, expBus);
		end
	endtask

	initial begin
		bit sawZero;

		seed = 88;
		wordErrors = 0;
		busErrors = 0;
		otherErrors = 0;
		cycleNum = 0;
		clk = 1'b0;
		reset = 1'b1;
		fillMemories();
		for (int r = 0; r < regCount; r++) begin
			mRegs[r] = '0;
		end
		mPc = '0;
		mCarry = 1'b0;
		mZero = 1'b0;

		// Hold reset 8 cycles while watching the fetch address clear
		sawZero = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			if (instrAddr === '0) sawZero = 1'b1;
			checkWord("dataBus.we", {15'd0, dataBus.we}, '0); // No stores in reset
			@(posedge clk);
		end
		reset <= 1'b0;

		if (!sawZero) begin
			otherErrors++;
			$display("Timed out waiting for instrAddr to read zero while reset was held");
		end else begin
			runProgram();
		end

		$display("Errors: word %0d, bus %0d, other %0d", wordErrors, busErrors, otherErrors);
		if (wordErrors + busErrors + otherErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
source/cpuPkg.sv
source/decoder.sv
source/regFile.sv
source/alu.sv
source/pcUnit.sv
source/cpuCore.sv
test/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module cpuCoreTb -o cpuCoreTb

simOut=$(./obj_dir/cpuCoreTb)
echo "$simOut"

if echo "$simOut" | grep -q "All checks passed"; then
	exit 0
else
	exit 1
fi
